//--- hw/io_proto_pkg.sv
// host I/O protocol definitions
// SPI frame layouts, user-I/O command codes and the core id
`default_nettype none

package io_proto_pkg;

  ////////////////////////////////////////
  // field widths
  ////////////////////////////////////////
  localparam int JOY_W       = 6;    // fire2, fire, up, down, left, right
  localparam int MOUSE_BTN_W = 3;    // mouse buttons
  localparam int KBD_CODE_W  = 8;    // amiga key code
  localparam int CPU_CFG_W   = 2;    // cpu type select
  localparam int MEMCFG_W    = 6;    // chip/slow/fast ram sizes

  ////////////////////////////////////////
  // user-I/O commands
  ////////////////////////////////////////
  localparam logic [7:0] CMD_JOY0      = 8'h01;
  localparam logic [7:0] CMD_JOY1      = 8'h02;
  localparam logic [7:0] CMD_MOUSE_BTN = 8'h04;
  localparam logic [7:0] CMD_KBD       = 8'h05;

  localparam logic [7:0] CORE_ID = 8'ha1;  // minimig core id

  // command byte goes first on the wire, msb first
  typedef struct packed {
    logic [7:0] cmd;
    logic [7:0] data;
  } user_frame_t;

  typedef struct packed {
    logic [CPU_CFG_W-1:0] cpu_config;  // upper bits
    logic [MEMCFG_W-1:0]  memcfg;
  } cfg_frame_t;

endpackage

`default_nettype wire

//--- hw/io_regmap_pkg.sv
// host I/O register map
// APB addresses and bit positions of the read-only registers
`default_nettype none

package io_regmap_pkg;

  localparam int APB_ADDR_W = 5;
  localparam int APB_DATA_W = 16;

  ////////////////////////////////////////
  // register addresses
  ////////////////////////////////////////
  localparam logic [APB_ADDR_W-1:0] REG_JOY   = 5'h00;  // joy1, joy0
  localparam logic [APB_ADDR_W-1:0] REG_MOUSE = 5'h04;  // mouse buttons
  localparam logic [APB_ADDR_W-1:0] REG_KBD   = 5'h08;  // key code and flags
  localparam logic [APB_ADDR_W-1:0] REG_CFG   = 5'h0c;  // memcfg, cpu_config

  ////////////////////////////////////////
  // field positions
  ////////////////////////////////////////
  localparam int JOY1_LSB     = 6;  // joy0 sits at bit 0
  localparam int KBD_PEND_BIT = 8;  // key waiting
  localparam int KBD_OVR_BIT  = 9;  // key lost
  localparam int CFG_MEM_LSB  = 2;  // cpu_config sits at bit 0

endpackage

`default_nettype wire

//--- hw/spi_line_sync.sv
// SPI pin synchronizer
// brings the host SPI pins into clk_28 and makes sck edge pulses
`timescale 1ns/1ns
`default_nettype none

module spi_line_sync (
  input  wire  clk_28,
  input  wire  pll_locked,
  input  wire  spi_sck,
  input  wire  spi_di,
  input  wire  conf_data0,
  input  wire  spi_ss3,
  output logic mosi,
  output logic user_sel_n,
  output logic cfg_sel_n,
  output logic sck_rise,
  output logic sck_fall
);

  logic [2:0] sck_q;  // two sync flops plus one for edge detect
  logic [1:0] di_q;
  logic [1:0] cd0_q;
  logic [1:0] ss3_q;

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      sck_q <= 3'b000;      // mode 0 idles low
      di_q  <= 2'b00;
      cd0_q <= 2'b11;       // selects idle deasserted
      ss3_q <= 2'b11;
    end else begin
      sck_q <= {sck_q[1:0], spi_sck};
      di_q  <= {di_q[0], spi_di};
      cd0_q <= {cd0_q[0], conf_data0};
      ss3_q <= {ss3_q[0], spi_ss3};
    end
  end

  assign mosi       = di_q[1];
  assign user_sel_n = cd0_q[1];
  assign cfg_sel_n  = ss3_q[1];
  assign sck_rise   = sck_q[1] & ~sck_q[2];  // one clk_28 wide
  assign sck_fall   = ~sck_q[1] & sck_q[2];

endmodule

`default_nettype wire

//--- hw/spi_frame_rx.sv
// SPI mode 0 slave frame receiver
// captures one frame_t per frame_t width of bits, shifts the reply out
`timescale 1ns/1ns
`default_nettype none

module spi_frame_rx #(
  parameter type frame_t = logic [7:0]
) (
  input  wire    clk_28,
  input  wire    pll_locked,
  input  wire    sel_n,
  input  wire    mosi,
  input  wire    sck_rise,
  input  wire    sck_fall,
  input  frame_t reply_frame,
  output frame_t frame,
  output logic   frame_valid,
  output logic   miso,
  output logic   miso_oe
);

  localparam int FRAME_W = $bits(frame_t);
  localparam int CNT_W   = $clog2(FRAME_W);

  logic               sel_q;      // select of last cycle
  logic               sel_fall;
  logic               last_bit;
  logic [CNT_W-1:0]   bit_cnt;
  logic [FRAME_W-1:0] in_shift;
  logic [FRAME_W-1:0] in_next;
  logic [FRAME_W-1:0] out_shift;

  assign sel_fall = sel_q & ~sel_n;
  assign last_bit = (bit_cnt == CNT_W'(FRAME_W - 1));
  assign in_next  = {in_shift[FRAME_W-2:0], mosi};

  ////////////////////////////////////////
  // bit count and reply shifter
  ////////////////////////////////////////
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      sel_q       <= 1'b1;
      bit_cnt     <= '0;
      frame_valid <= 1'b0;
      out_shift   <= '0;
    end else begin
      sel_q       <= sel_n;
      frame_valid <= 1'b0;
      if (sel_fall) begin
        out_shift <= reply_frame;                // first bit ready before first rise
        bit_cnt   <= '0;
      end else if (!sel_n) begin
        if (sck_rise) begin
          bit_cnt     <= last_bit ? '0 : bit_cnt + 1'b1;
          frame_valid <= last_bit;               // single pulse per frame
        end
        if (sck_fall) begin
          if (bit_cnt == '0)
            out_shift <= reply_frame;            // frame boundary, fresh reply
          else
            out_shift <= {out_shift[FRAME_W-2:0], 1'b0};
        end
      end
    end
  end

  // capture path, payload only
  always_ff @(posedge clk_28) begin
    if (!sel_n && sck_rise) begin
      in_shift <= in_next;
      if (last_bit)
        frame <= frame_t'(in_next);
    end
  end

  assign miso    = out_shift[FRAME_W-1];  // msb first
  assign miso_oe = ~sel_n;

endmodule

`default_nettype wire

//--- hw/user_io_regs.sv
// user-I/O register block
// decodes joystick, mouse and keyboard commands from user frames
`timescale 1ns/1ns
`default_nettype none

module user_io_regs import io_proto_pkg::*; (
  input  wire                     clk_28,
  input  wire                     pll_locked,
  input  user_frame_t             frame,
  input  wire                     frame_valid,
  input  wire                     kbd_read,
  output logic [JOY_W-1:0]        joy0,
  output logic [JOY_W-1:0]        joy1,
  output logic [MOUSE_BTN_W-1:0]  mouse_btn,
  output logic [KBD_CODE_W-1:0]   kbd_code,
  output logic                    kbd_pending,
  output logic                    kbd_overrun,
  output user_frame_t             reply_frame
);

  logic key_in;  // key frame this cycle

  assign key_in = frame_valid && (frame.cmd == CMD_KBD);

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      joy0        <= '0;
      joy1        <= '0;
      mouse_btn   <= '0;
      kbd_code    <= '0;
      kbd_pending <= 1'b0;
      kbd_overrun <= 1'b0;
    end else begin
      if (frame_valid) begin
        case (frame.cmd)
          CMD_JOY0:      joy0      <= frame.data[JOY_W-1:0];
          CMD_JOY1:      joy1      <= frame.data[JOY_W-1:0];
          CMD_MOUSE_BTN: mouse_btn <= frame.data[MOUSE_BTN_W-1:0];
          CMD_KBD:       kbd_code  <= frame.data[KBD_CODE_W-1:0];
          default: ;                         // unknown code, no change
        endcase
      end
      // new key beats a read-clear in the same cycle
      kbd_pending <= key_in | (kbd_pending & ~kbd_read);
      kbd_overrun <= (key_in & kbd_pending & ~kbd_read) | (kbd_overrun & ~kbd_read);
    end
  end

  assign reply_frame.cmd  = CORE_ID;
  assign reply_frame.data = 8'(joy0);  // zero extended

endmodule

`default_nettype wire

//--- hw/core_cfg_regs.sv
// core configuration registers
// keeps the last OSD config frame and echoes it as the reply
`timescale 1ns/1ns
`default_nettype none

module core_cfg_regs import io_proto_pkg::*; (
  input  wire                   clk_28,
  input  wire                   pll_locked,
  input  cfg_frame_t            frame,
  input  wire                   frame_valid,
  output logic [CPU_CFG_W-1:0]  cpu_config,
  output logic [MEMCFG_W-1:0]   memcfg,
  output cfg_frame_t            reply_frame
);

  cfg_frame_t cfg_q;  // last config written

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked)
      cfg_q <= '0;                  // 68000, minimal memory
    else if (frame_valid)
      cfg_q <= frame;
  end

  assign cpu_config  = cfg_q.cpu_config;
  assign memcfg      = cfg_q.memcfg;
  assign reply_frame = cfg_q;     // read back for the controller

endmodule

`default_nettype wire

//--- hw/host_io_merge.sv
// host I/O merge
// picks the SPI data-out source and serves all registers over APB
`timescale 1ns/1ns
`default_nettype none

module host_io_merge import io_proto_pkg::*, io_regmap_pkg::*; (
  input  wire                    clk_28,
  input  wire                    pll_locked,
  input  wire                    user_miso,
  input  wire                    user_miso_oe,
  input  wire                    cfg_miso,
  input  wire                    cfg_miso_oe,
  input  wire [JOY_W-1:0]        joy0,
  input  wire [JOY_W-1:0]        joy1,
  input  wire [MOUSE_BTN_W-1:0]  mouse_btn,
  input  wire [KBD_CODE_W-1:0]   kbd_code,
  input  wire                    kbd_pending,
  input  wire                    kbd_overrun,
  input  wire [CPU_CFG_W-1:0]    cpu_config,
  input  wire [MEMCFG_W-1:0]     memcfg,
  input  wire                    psel,
  input  wire                    penable,
  input  wire                    pwrite,
  input  wire [APB_ADDR_W-1:0]   paddr,
  input  wire [APB_DATA_W-1:0]   pwdata,      // registers are read only
  output logic                   spi_do,
  output logic                   spi_do_oe,
  output logic [APB_DATA_W-1:0]  prdata,
  output logic                   kbd_read
);

  logic                  access;  // apb access phase
  logic [APB_DATA_W-1:0] rdata;

  ////////////////////////////////////////
  // spi data out, user channel first
  ////////////////////////////////////////
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      spi_do    <= 1'b0;
      spi_do_oe <= 1'b0;
    end else begin
      spi_do    <= user_miso_oe ? user_miso : cfg_miso;
      spi_do_oe <= user_miso_oe | cfg_miso_oe;
    end
  end

  ////////////////////////////////////////
  // apb read decode
  ////////////////////////////////////////
  assign access = psel & penable;

  always_comb begin
    rdata = '0;                                   // holes read zero
    case (paddr)
      REG_JOY: begin
        rdata[JOY1_LSB +: JOY_W] = joy1;
        rdata[JOY_W-1:0]         = joy0;
      end
      REG_MOUSE: rdata[MOUSE_BTN_W-1:0] = mouse_btn;
      REG_KBD: begin
        rdata[KBD_CODE_W-1:0] = kbd_code;
        rdata[KBD_PEND_BIT]   = kbd_pending;
        rdata[KBD_OVR_BIT]    = kbd_overrun;
      end
      REG_CFG: begin
        rdata[CFG_MEM_LSB +: MEMCFG_W] = memcfg;
        rdata[CPU_CFG_W-1:0]           = cpu_config;
      end
      default: ;
    endcase
  end

  assign prdata   = access ? rdata : '0;          // zero outside access phase
  assign kbd_read = access & ~pwrite & (paddr == REG_KBD);  // clears flags

endmodule

`default_nettype wire

//--- hw/host_io_top.sv
// host I/O top level
// SPI user-I/O and config channels with an APB register view
`timescale 1ns/1ns
`default_nettype none

module host_io_top import io_proto_pkg::*, io_regmap_pkg::*; (
  input  wire                    clk_28,
  input  wire                    pll_locked,
  input  wire                    spi_sck,
  input  wire                    spi_di,
  input  wire                    conf_data0,  // user-I/O select
  input  wire                    spi_ss3,     // OSD select
  output logic                   spi_do,
  output logic                   spi_do_oe,
  input  wire                    psel,
  input  wire                    penable,
  input  wire                    pwrite,
  input  wire [APB_ADDR_W-1:0]   paddr,
  input  wire [APB_DATA_W-1:0]   pwdata,
  output logic [APB_DATA_W-1:0]  prdata
);

  logic mosi, user_sel_n, cfg_sel_n, sck_rise, sck_fall;
  logic user_valid, user_miso, user_miso_oe;
  logic cfg_valid, cfg_miso, cfg_miso_oe;
  logic kbd_pending, kbd_overrun, kbd_read;
  user_frame_t user_frame, user_reply;
  cfg_frame_t cfg_frame, cfg_reply;
  logic [JOY_W-1:0] joy0, joy1;
  logic [MOUSE_BTN_W-1:0] mouse_btn;
  logic [KBD_CODE_W-1:0] kbd_code;
  logic [CPU_CFG_W-1:0] cpu_config;
  logic [MEMCFG_W-1:0] memcfg;

  spi_line_sync sync_i (
    .clk_28(clk_28), .pll_locked(pll_locked), .spi_sck(spi_sck), .spi_di(spi_di),
    .conf_data0(conf_data0), .spi_ss3(spi_ss3), .mosi(mosi), .user_sel_n(user_sel_n),
    .cfg_sel_n(cfg_sel_n), .sck_rise(sck_rise), .sck_fall(sck_fall));

  spi_frame_rx #(.frame_t(user_frame_t)) user_rx (
    .clk_28(clk_28), .pll_locked(pll_locked), .sel_n(user_sel_n), .mosi(mosi),
    .sck_rise(sck_rise), .sck_fall(sck_fall), .reply_frame(user_reply), .frame(user_frame),
    .frame_valid(user_valid), .miso(user_miso), .miso_oe(user_miso_oe));

  spi_frame_rx #(.frame_t(cfg_frame_t)) cfg_rx (
    .clk_28(clk_28), .pll_locked(pll_locked), .sel_n(cfg_sel_n), .mosi(mosi),
    .sck_rise(sck_rise), .sck_fall(sck_fall), .reply_frame(cfg_reply), .frame(cfg_frame),
    .frame_valid(cfg_valid), .miso(cfg_miso), .miso_oe(cfg_miso_oe));

  user_io_regs user_regs_i (
    .clk_28(clk_28), .pll_locked(pll_locked), .frame(user_frame), .frame_valid(user_valid),
    .kbd_read(kbd_read), .joy0(joy0), .joy1(joy1), .mouse_btn(mouse_btn),
    .kbd_code(kbd_code), .kbd_pending(kbd_pending), .kbd_overrun(kbd_overrun),
    .reply_frame(user_reply));

  core_cfg_regs cfg_regs_i (
    .clk_28(clk_28), .pll_locked(pll_locked), .frame(cfg_frame), .frame_valid(cfg_valid),
    .cpu_config(cpu_config), .memcfg(memcfg), .reply_frame(cfg_reply));

  host_io_merge merge_i (
    .clk_28(clk_28), .pll_locked(pll_locked), .user_miso(user_miso),
    .user_miso_oe(user_miso_oe), .cfg_miso(cfg_miso), .cfg_miso_oe(cfg_miso_oe),
    .joy0(joy0), .joy1(joy1), .mouse_btn(mouse_btn), .kbd_code(kbd_code),
    .kbd_pending(kbd_pending), .kbd_overrun(kbd_overrun), .cpu_config(cpu_config),
    .memcfg(memcfg), .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .spi_do(spi_do), .spi_do_oe(spi_do_oe), .prdata(prdata),
    .kbd_read(kbd_read));

endmodule

`default_nettype wire

//--- sim/host_io_assert.sv
// frame receiver checks
// bound into every spi_frame_rx instance
`timescale 1ns/1ns
`default_nettype none

module host_io_assert (
  input wire clk_28,
  input wire pll_locked,
  input wire sel_n,
  input wire frame_valid,
  input wire miso_oe
);

  valid_one_cycle: assert property (@(posedge clk_28) disable iff (!pll_locked)
    frame_valid |=> !frame_valid)                        // one pulse per frame
    else $error("frame_valid high for two cycles");

  oe_from_sel: assert property (@(posedge clk_28) miso_oe == ~sel_n)
    else $error("miso_oe does not follow sel_n");

  no_valid_in_reset: assert property (@(posedge clk_28) !pll_locked |-> !frame_valid)
    else $error("frame_valid during reset");

endmodule

`default_nettype wire

//--- sim/host_io_tb.sv
// host I/O testbench
// drives both SPI channels and the APB port, checks replies and registers
`timescale 1ns/1ns
`default_nettype none

module host_io_tb import io_proto_pkg::*, io_regmap_pkg::*; ();

  localparam logic [31:0] SEED = 32'hd17a_862e;
  localparam int HALF_CLKS = 5;   // 10 clk_28 per sck bit
  localparam int IDLE_CLKS = 6;   // select high between frames
  localparam int POLL_MAX  = 8;   // apb reads per register wait
  localparam int OE_MAX    = 10;  // cycles for enable to settle

  logic                  clk_28;
  logic                  pll_locked;
  logic                  spi_sck;
  logic                  spi_di;
  logic                  conf_data0;
  logic                  spi_ss3;
  logic                  spi_do;
  logic                  spi_do_oe;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;

  logic [JOY_W-1:0]       exp_joy0;   // reference model
  logic [JOY_W-1:0]       exp_joy1;
  logic [MOUSE_BTN_W-1:0] exp_mouse;
  cfg_frame_t             exp_cfg;

  host_io_top host_io_top_i (
    .clk_28(clk_28), .pll_locked(pll_locked), .spi_sck(spi_sck), .spi_di(spi_di),
    .conf_data0(conf_data0), .spi_ss3(spi_ss3), .spi_do(spi_do), .spi_do_oe(spi_do_oe),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata));

  bind spi_frame_rx host_io_assert rx_assert_i (
    .clk_28(clk_28), .pll_locked(pll_locked), .sel_n(sel_n),
    .frame_valid(frame_valid), .miso_oe(miso_oe));

  always #4 clk_28 = ~clk_28;  // 8 ns period

  ////////////////////////////////////////
  // reporting and compares
  ////////////////////////////////////////
  task automatic stop_run();
    $display("Test FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input logic [APB_DATA_W-1:0] got, exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_frame(input user_frame_t got, exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_cfg(input cfg_frame_t got, exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input logic got, exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  ////////////////////////////////////////
  // expected register words
  ////////////////////////////////////////
  function automatic logic [APB_DATA_W-1:0] joy_word();
    logic [APB_DATA_W-1:0] w;
    w = '0;
    w[JOY1_LSB +: JOY_W] = exp_joy1;
    w[JOY_W-1:0]         = exp_joy0;
    return w;
  endfunction

  function automatic logic [APB_DATA_W-1:0] cfg_word();
    logic [APB_DATA_W-1:0] w;
    w = '0;
    w[CFG_MEM_LSB +: MEMCFG_W] = exp_cfg.memcfg;
    w[CPU_CFG_W-1:0]           = exp_cfg.cpu_config;
    return w;
  endfunction

  function automatic logic [APB_DATA_W-1:0] kbd_word(input logic [7:0] code,
                                                    input logic pend, input logic ovr);
    logic [APB_DATA_W-1:0] w;
    w = '0;
    w[7:0]          = code;
    w[KBD_PEND_BIT] = pend;
    w[KBD_OVR_BIT]  = ovr;
    return w;
  endfunction

  function automatic user_frame_t user_reply();
    user_frame_t f;
    f.cmd  = CORE_ID;
    f.data = {2'b00, exp_joy0};  // joy0 zero extended
    return f;
  endfunction

  ////////////////////////////////////////
  // bus drivers
  ////////////////////////////////////////
  // mode 0 master, msb first, one frame per select
  task automatic spi_xfer(input logic user_sel, cfg_sel, input int nbits,
                          input logic [15:0] tx, output logic [15:0] rx);
    logic [15:0] tx_q;
    tx_q = tx << (16 - nbits);  // first bit to the top
    rx   = '0;
    @(posedge clk_28);
    conf_data0 <= ~user_sel;
    spi_ss3    <= ~cfg_sel;
    spi_di     <= tx_q[15];
    for (int i = 0; i < nbits; i++) begin
      repeat (HALF_CLKS) @(posedge clk_28);
      spi_sck <= 1'b1;
      rx = {rx[14:0], spi_do};  // sample on rising sck
      tx_q = tx_q << 1;
      repeat (HALF_CLKS) @(posedge clk_28);
      spi_sck <= 1'b0;
      spi_di  <= tx_q[15];      // change on falling sck
    end
    repeat (HALF_CLKS) @(posedge clk_28);
    conf_data0 <= 1'b1;
    spi_ss3    <= 1'b1;
    repeat (IDLE_CLKS) @(posedge clk_28);
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr,
                          output logic [APB_DATA_W-1:0] data);
    @(posedge clk_28);
    psel    <= 1'b1;  // setup
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge clk_28);
    penable <= 1'b1;  // access
    @(posedge clk_28);
    data = prdata;    // value of the access cycle
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  ////////////////////////////////////////
  // waits
  ////////////////////////////////////////
  task automatic poll_reg(input logic [APB_ADDR_W-1:0] addr,
                          input logic [APB_DATA_W-1:0] exp, input string what);
    logic [APB_DATA_W-1:0] got;
    int tries;
    tries = 0;
    apb_read(addr, got);
    while (got !== exp && tries < POLL_MAX) begin
      tries++;
      apb_read(addr, got);
    end
    if (got !== exp)
      $display("timeout: waiting for the %s register update expired", what);
    check_word(got, exp, what);
  endtask

  task automatic wait_oe(input logic exp, input string what);
    int n;
    n = 0;
    while (spi_do_oe !== exp && n < OE_MAX) begin
      @(posedge clk_28);
      n++;
    end
    if (spi_do_oe !== exp) begin
      $display("timeout: spi_do_oe never became %0b %s", exp, what);
      stop_run();
    end
  endtask

  task automatic send_user(input logic [7:0] cmd, input logic [7:0] data);
    logic [15:0] rx;
    spi_xfer(1'b1, 1'b0, 16, {cmd, data}, rx);
    check_frame(user_frame_t'(rx), user_reply(), "user reply");
    case (cmd)
      CMD_JOY0:      exp_joy0  = data[JOY_W-1:0];  // truncated to field
      CMD_JOY1:      exp_joy1  = data[JOY_W-1:0];
      CMD_MOUSE_BTN: exp_mouse = data[MOUSE_BTN_W-1:0];
      default: ;
    endcase
  endtask

  task automatic send_cfg(input logic [7:0] data);
    logic [15:0] rx;
    spi_xfer(1'b0, 1'b1, 8, {8'h00, data}, rx);
    check_cfg(cfg_frame_t'(rx[7:0]), exp_cfg, "config reply");  // previous config
    exp_cfg = cfg_frame_t'(data);
    poll_reg(REG_CFG, cfg_word(), "REG_CFG");
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic test_reset();
    poll_reg(REG_JOY, '0, "REG_JOY after reset");
    poll_reg(REG_MOUSE, '0, "REG_MOUSE after reset");
    poll_reg(REG_KBD, '0, "REG_KBD after reset");
    poll_reg(REG_CFG, '0, "REG_CFG after reset");
    check_bit(spi_do_oe, 1'b0, "spi_do_oe after reset");
  endtask

  task automatic test_user_regs();
    for (int i = 0; i < 3; i++) begin
      send_user(CMD_JOY0, 8'($urandom));
      send_user(CMD_JOY1, 8'($urandom));
      send_user(CMD_MOUSE_BTN, 8'($urandom));
      poll_reg(REG_JOY, joy_word(), "REG_JOY");
      poll_reg(REG_MOUSE, {13'd0, exp_mouse}, "REG_MOUSE");
    end
    send_user(8'h03, 8'($urandom));  // unknown codes
    send_user(8'h7f, 8'($urandom));
    poll_reg(REG_JOY, joy_word(), "REG_JOY after unknown command");
    poll_reg(REG_MOUSE, {13'd0, exp_mouse}, "REG_MOUSE after unknown command");
  endtask

  task automatic test_user_reply();
    for (int i = 0; i < 3; i++) begin
      send_user(CMD_JOY0, 8'($urandom));
      send_user(8'h00, 8'($urandom));  // reply shows the new joy0
    end
  endtask

  task automatic test_cfg();
    send_cfg(8'($urandom));
    send_cfg(8'($urandom));
    send_cfg(8'($urandom));
  endtask

  task automatic test_kbd();
    logic [7:0] k1;
    logic [7:0] k3;
    logic [APB_DATA_W-1:0] got;
    k1 = 8'($urandom);
    k3 = 8'($urandom);
    send_user(CMD_KBD, k1);
    poll_reg(REG_KBD, kbd_word(k1, 1'b1, 1'b0), "REG_KBD one key");
    send_user(CMD_KBD, 8'($urandom));
    send_user(CMD_KBD, k3);                                // second key overruns
    poll_reg(REG_KBD, kbd_word(k3, 1'b1, 1'b1), "REG_KBD two keys");
    apb_read(REG_KBD, got);
    check_word(got, kbd_word(k3, 1'b0, 1'b0), "REG_KBD after read");
  endtask

  task automatic test_dout_select();
    logic [7:0]  d;
    logic [15:0] rx;
    d = 8'($urandom);
    @(posedge clk_28);
    conf_data0 <= 1'b0;
    wait_oe(1'b1, "with conf_data0 low");
    @(posedge clk_28);
    conf_data0 <= 1'b1;
    wait_oe(1'b0, "after conf_data0 rose");
    send_user(8'h00, d);                          // user data on spi_do
    @(posedge clk_28);
    spi_ss3 <= 1'b0;
    wait_oe(1'b1, "with spi_ss3 low");
    @(posedge clk_28);
    spi_ss3 <= 1'b1;
    wait_oe(1'b0, "after spi_ss3 rose");
    send_cfg(8'($urandom));                       // config data on spi_do
    @(posedge clk_28);
    conf_data0 <= 1'b0;
    spi_ss3    <= 1'b0;
    wait_oe(1'b1, "with both selects low");
    @(posedge clk_28);
    conf_data0 <= 1'b1;
    spi_ss3    <= 1'b1;
    wait_oe(1'b0, "after both selects rose");
    spi_xfer(1'b1, 1'b1, 16, {8'h00, d}, rx);     // user reply wins
    check_frame(user_frame_t'(rx), user_reply(), "reply with both selects");
    exp_cfg = cfg_frame_t'(d);                    // config rx saw two frames
    poll_reg(REG_CFG, cfg_word(), "REG_CFG after shared transfer");
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    clk_28     = 1'b0;
    pll_locked = 1'b0;
    spi_sck    = 1'b0;
    spi_di     = 1'b0;
    conf_data0 = 1'b1;
    spi_ss3    = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    exp_joy0   = '0;
    exp_joy1   = '0;
    exp_mouse  = '0;
    exp_cfg    = '0;
    void'($urandom(SEED));  // one seed for the whole run
    repeat (5) @(posedge clk_28);
    pll_locked <= 1'b1;
    test_reset();
    test_user_regs();
    test_user_reply();
    test_cfg();
    test_kbd();
    test_dout_select();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hw/io_proto_pkg.sv
hw/io_regmap_pkg.sv
hw/spi_line_sync.sv
hw/spi_frame_rx.sv
hw/user_io_regs.sv
hw/core_cfg_regs.sv
hw/host_io_merge.sv
hw/host_io_top.sv
sim/host_io_assert.sv
sim/host_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the host I/O testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module host_io_tb -o host_io_sim
./obj_dir/host_io_sim 2>&1 | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
